// ==== all.f ====
disp_pkg.sv
vga_pkg.sv
debounce.sv
ps2_keyboard.sv
step_counter.sv
seven_hex_decoder.sv
vga_sync.sv
de2_115_top.sv
tb_clock_gen.sv
tb_de2_115.sv

// ==== de2_115_top.sv ====
module de2_115_top #(
	// short timing for simulation, the board needs about 250000 and 640x480
	parameter int DEB_CYCLES = 8,
	parameter int H_ACTIVE   = 16,
	parameter int H_FP       = 2,
	parameter int H_SYNC     = 4,
	parameter int H_BP       = 2,
	parameter int V_ACTIVE   = 8,
	parameter int V_FP       = 1,
	parameter int V_SYNC     = 2,
	parameter int V_BP       = 1
) (
	input  logic              i_clk,
	input  logic              i_arst_n,
	input  logic [2:0]        i_key,
	input  logic              i_ps2_clk,
	input  logic              i_ps2_dat,
	output disp_pkg::seg_t    o_hex0,
	output disp_pkg::seg_t    o_hex1,
	output disp_pkg::seg_t    o_hex2,
	output disp_pkg::seg_t    o_hex3,
	output disp_pkg::seg_t    o_hex4,
	output disp_pkg::seg_t    o_hex5,
	output disp_pkg::seg_t    o_hex6,
	output disp_pkg::seg_t    o_hex7,
	output vga_pkg::color_t   o_vga_r,
	output vga_pkg::color_t   o_vga_g,
	output vga_pkg::color_t   o_vga_b,
	output logic              o_vga_hs,
	output logic              o_vga_vs,
	output logic              o_vga_blank_n
);

	import disp_pkg::*;

	logic [2:0] key_down;
	digit_t num1;
	digit_t num2;
	digit_t value;
	digit_t err_cnt;

	// key0 up, key1 down, key2 clear
	for (genvar k = 0; k < 3; k++) begin : g_deb
		debounce #(
			.DEB_CYCLES(DEB_CYCLES)
		) debounce_i (
			.i_clk(i_clk),
			.i_arst_n(i_arst_n),
			.i_in(i_key[k]),
			.o_neg(key_down[k])
		);
	end

	step_counter step_counter_i (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_up(key_down[0]),
		.i_down(key_down[1]),
		.i_clr(key_down[2]),
		.o_value(value)
	);

	ps2_keyboard ps2_keyboard_i (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_ps2_clk(i_ps2_clk),
		.i_ps2_dat(i_ps2_dat),
		.o_num1(num1),
		.o_num2(num2),
		.o_err_cnt(err_cnt)
	);

	// tens digit on the odd display of each pair
	seven_hex_decoder seven_dec0 (
		.i_hex(num1),
		.o_seven_ten(o_hex1),
		.o_seven_one(o_hex0)
	);
	seven_hex_decoder seven_dec1 (
		.i_hex(num2),
		.o_seven_ten(o_hex3),
		.o_seven_one(o_hex2)
	);
	seven_hex_decoder seven_dec2 (
		.i_hex(value),
		.o_seven_ten(o_hex5),
		.o_seven_one(o_hex4)
	);
	seven_hex_decoder seven_dec3 (
		.i_hex(err_cnt),
		.o_seven_ten(o_hex7),
		.o_seven_one(o_hex6)
	);

	vga_sync #(
		.H_ACTIVE(H_ACTIVE),
		.H_FP(H_FP),
		.H_SYNC(H_SYNC),
		.H_BP(H_BP),
		.V_ACTIVE(V_ACTIVE),
		.V_FP(V_FP),
		.V_SYNC(V_SYNC),
		.V_BP(V_BP)
	) vga_sync_i (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_num1(num1),
		.i_num2(num2),
		.i_value(value),
		.o_vga_r(o_vga_r),
		.o_vga_g(o_vga_g),
		.o_vga_b(o_vga_b),
		.o_vga_hs(o_vga_hs),
		.o_vga_vs(o_vga_vs),
		.o_vga_blank_n(o_vga_blank_n)
	);

endmodule

// ==== debounce.sv ====
module debounce #(
	parameter int DEB_CYCLES = 8
) (
	input  logic i_clk,
	input  logic i_arst_n,
	input  logic i_in,
	output logic o_neg
);

	localparam int CNT_W = $clog2(DEB_CYCLES + 1);

	typedef enum logic {
		ST_STABLE,
		ST_CHANGING
	} deb_state_t;

	deb_state_t state;
	logic sync0;
	logic sync1;
	logic held;
	logic held_d;
	logic [CNT_W-1:0] cnt;

	// keys idle high, so the synchronizer and held level reset to 1
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			sync0 <= 1'b1;
			sync1 <= 1'b1;
		end else begin
			sync0 <= i_in;
			sync1 <= sync0;
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= ST_STABLE;
			held  <= 1'b1;
			cnt   <= '0;
		end else begin
			case (state)
				ST_STABLE: begin
					if (sync1 != held) begin
						state <= ST_CHANGING;
						cnt   <= CNT_W'(1);
					end
				end
				ST_CHANGING: begin
					if (sync1 == held) begin
						// glitch, level went back before the count ran out
						state <= ST_STABLE;
						cnt   <= '0;
					end else if (cnt == CNT_W'(DEB_CYCLES - 1)) begin
						state <= ST_STABLE;
						held  <= sync1;
						cnt   <= '0;
					end else begin
						cnt <= cnt + CNT_W'(1);
					end
				end
				default: state <= ST_STABLE;
			endcase
		end
	end

	// press pulse on the 1 to 0 step of the held level
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			held_d <= 1'b1;
			o_neg  <= 1'b0;
		end else begin
			held_d <= held;
			o_neg  <= held_d & ~held;
		end
	end

	a_neg_single : assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_neg |=> !o_neg);

endmodule

// ==== disp_pkg.sv ====
package disp_pkg;

	// one displayed value, 0 to 15
	typedef logic [3:0] digit_t;

	// active low, bit 0 is segment a and bit 6 is segment g
	typedef logic [6:0] seg_t;

	// decimal digit to segment pattern, anything above 9 is blank
	function automatic seg_t seg_lut(input digit_t d);
		seg_t seg;
		case (d)
			4'd0: seg = 7'b1000000;
			4'd1: seg = 7'b1111001;
			4'd2: seg = 7'b0100100;
			4'd3: seg = 7'b0110000;
			4'd4: seg = 7'b0011001;
			4'd5: seg = 7'b0010010;
			4'd6: seg = 7'b0000010;
			4'd7: seg = 7'b1111000;
			4'd8: seg = 7'b0000000;
			4'd9: seg = 7'b0010000;
			default: seg = 7'b1111111;
		endcase
		return seg;
	endfunction

endpackage

// ==== ps2_keyboard.sv ====
module ps2_keyboard (
	input  logic              i_clk,
	input  logic              i_arst_n,
	input  logic              i_ps2_clk,
	input  logic              i_ps2_dat,
	output disp_pkg::digit_t  o_num1,
	output disp_pkg::digit_t  o_num2,
	output disp_pkg::digit_t  o_err_cnt
);

	import disp_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DATA,
		ST_PARITY,
		ST_STOP
	} ps2_state_t;

	ps2_state_t state;
	logic clk_s0;
	logic clk_s1;
	logic clk_d;
	logic dat_s0;
	logic dat_s1;
	logic ps2_fall;
	logic [3:0] bit_cnt;
	logic [7:0] shreg;
	logic par_bit;
	logic brk;
	logic frame_ok;
	logic [4:0] dec;

	// make code to {valid, digit}
	function automatic logic [4:0] code_to_digit(input logic [7:0] code);
		logic [4:0] res;
		case (code)
			8'h45: res = {1'b1, 4'd0};
			8'h16: res = {1'b1, 4'd1};
			8'h1e: res = {1'b1, 4'd2};
			8'h26: res = {1'b1, 4'd3};
			8'h25: res = {1'b1, 4'd4};
			8'h2e: res = {1'b1, 4'd5};
			8'h36: res = {1'b1, 4'd6};
			8'h3d: res = {1'b1, 4'd7};
			8'h3e: res = {1'b1, 4'd8};
			8'h46: res = {1'b1, 4'd9};
			default: res = 5'd0;
		endcase
		return res;
	endfunction

	// bring the keyboard lines into the system clock, both idle high
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			clk_s0 <= 1'b1;
			clk_s1 <= 1'b1;
			clk_d  <= 1'b1;
			dat_s0 <= 1'b1;
			dat_s1 <= 1'b1;
		end else begin
			clk_s0 <= i_ps2_clk;
			clk_s1 <= clk_s0;
			clk_d  <= clk_s1;
			dat_s0 <= i_ps2_dat;
			dat_s1 <= dat_s0;
		end
	end

	assign ps2_fall = clk_d & ~clk_s1;

	// odd parity over data plus parity bit, stop must be 1
	assign frame_ok = dat_s1 & (^{shreg, par_bit});
	assign dec      = code_to_digit(shreg);

	always_ff @(posedge i_clk) begin
		if (ps2_fall && state == ST_DATA) begin
			shreg <= {dat_s1, shreg[7:1]};
		end
		if (ps2_fall && state == ST_PARITY) begin
			par_bit <= dat_s1;
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state     <= ST_IDLE;
			bit_cnt   <= '0;
			brk       <= 1'b0;
			o_num1    <= '0;
			o_num2    <= '0;
			o_err_cnt <= '0;
		end else if (ps2_fall) begin
			case (state)
				ST_IDLE: begin
					// wait for the start bit
					if (!dat_s1) begin
						state   <= ST_DATA;
						bit_cnt <= '0;
					end
				end
				ST_DATA: begin
					if (bit_cnt == 4'd7) begin
						state <= ST_PARITY;
					end else begin
						bit_cnt <= bit_cnt + 4'd1;
					end
				end
				ST_PARITY: state <= ST_STOP;
				ST_STOP: begin
					state <= ST_IDLE;
					if (!frame_ok) begin
						if (o_err_cnt != 4'hf) begin
							o_err_cnt <= o_err_cnt + 4'd1;
						end
					end else if (shreg == 8'hf0) begin
						brk <= 1'b1;
					end else if (brk) begin
						// key release, drop the code
						brk <= 1'b0;
					end else if (dec[4]) begin
						o_num2 <= o_num1;
						o_num1 <= digit_t'(dec[3:0]);
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	a_bit_cnt_range : assert property (@(posedge i_clk) disable iff (!i_arst_n)
		(state == ST_DATA) |-> (bit_cnt <= 4'd7));

endmodule

// ==== seven_hex_decoder.sv ====
module seven_hex_decoder (
	input  disp_pkg::digit_t  i_hex,
	output disp_pkg::seg_t    o_seven_ten,
	output disp_pkg::seg_t    o_seven_one
);

	import disp_pkg::*;

	digit_t tens;
	digit_t ones;

	// at most 15, so the tens digit is only ever 0 or 1
	always_comb begin
		if (i_hex >= digit_t'(10)) begin
			tens = digit_t'(1);
			ones = i_hex - digit_t'(10);
		end else begin
			tens = '0;
			ones = i_hex;
		end
	end

	assign o_seven_ten = seg_lut(tens);
	assign o_seven_one = seg_lut(ones);

endmodule

// ==== step_counter.sv ====
module step_counter (
	input  logic              i_clk,
	input  logic              i_arst_n,
	input  logic              i_up,
	input  logic              i_down,
	input  logic              i_clr,
	output disp_pkg::digit_t  o_value
);

	import disp_pkg::*;

	// clear first, then a single direction, wraps mod 16
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_value <= '0;
		end else if (i_clr) begin
			o_value <= '0;
		end else if (i_up && !i_down) begin
			o_value <= o_value + digit_t'(1);
		end else if (i_down && !i_up) begin
			o_value <= o_value - digit_t'(1);
		end
	end

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen #(
	parameter int PERIOD     = 20,
	parameter int RST_CYCLES = 3
) (
	output logic o_clk,
	output logic o_arst_n
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD / 2) o_clk = ~o_clk;
	end

	// reset released on a falling edge, away from the sampling edge
	initial begin
		o_arst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge o_clk);
		@(negedge o_clk);
		o_arst_n = 1'b1;
	end

endmodule

// ==== tb_de2_115.sv ====
module tb_de2_115;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int DEB_CYCLES = 8;
	localparam int PS2_HALF   = 10;
	localparam int WAIT_LIMIT = 2000;
	localparam int N_ROWS     = 16;
	localparam int LINE_CLKS  = 24;
	localparam int HS_CLKS    = 4;
	localparam int FRAME_CLKS = 288;
	localparam int VS_CLKS    = 48;
	localparam int VGA_CLKS   = 800;

	localparam int ACT_WAIT    = 0;
	localparam int ACT_KEY     = 1;
	localparam int ACT_GLITCH  = 2;
	localparam int ACT_PS2     = 3;
	localparam int ACT_PS2_BAD = 4;

	logic clk;
	logic arst_n;
	logic [2:0] key;
	logic ps2_clk;
	logic ps2_dat;
	logic [6:0] hex [0:7];
	logic [7:0] vga_r;
	logic [7:0] vga_g;
	logic [7:0] vga_b;
	logic vga_hs;
	logic vga_vs;
	logic vga_blank_n;

	// stimulus table with the expected display values after each row
	int act [N_ROWS];
	logic [7:0] arg [N_ROWS];
	logic [3:0] e_num1 [N_ROWS];
	logic [3:0] e_num2 [N_ROWS];
	logic [3:0] e_val [N_ROWS];
	logic [3:0] e_err [N_ROWS];
	logic [6:0] exp_hex [0:7];
	int n_rows;
	int errors;
	int timeouts;
	int cnt;
	integer seed;

	tb_clock_gen #(
		.PERIOD(20),
		.RST_CYCLES(3)
	) clock_gen_i (
		.o_clk(clk),
		.o_arst_n(arst_n)
	);

	de2_115_top #(
		.DEB_CYCLES(DEB_CYCLES)
	) de2_115_top_i (
		.i_clk(clk),
		.i_arst_n(arst_n),
		.i_key(key),
		.i_ps2_clk(ps2_clk),
		.i_ps2_dat(ps2_dat),
		.o_hex0(hex[0]),
		.o_hex1(hex[1]),
		.o_hex2(hex[2]),
		.o_hex3(hex[3]),
		.o_hex4(hex[4]),
		.o_hex5(hex[5]),
		.o_hex6(hex[6]),
		.o_hex7(hex[7]),
		.o_vga_r(vga_r),
		.o_vga_g(vga_g),
		.o_vga_b(vga_b),
		.o_vga_hs(vga_hs),
		.o_vga_vs(vga_vs),
		.o_vga_blank_n(vga_blank_n)
	);

	// active low with segment a in bit 0
	function automatic logic [6:0] seg_pattern(input int d);
		case (d)
			0: return 7'b1000000;
			1: return 7'b1111001;
			2: return 7'b0100100;
			3: return 7'b0110000;
			4: return 7'b0011001;
			5: return 7'b0010010;
			6: return 7'b0000010;
			7: return 7'b1111000;
			8: return 7'b0000000;
			9: return 7'b0010000;
			default: return 7'b1111111;
		endcase
	endfunction

	task automatic add_row(input int a, input logic [7:0] g, input logic [3:0] n1,
			input logic [3:0] n2, input logic [3:0] v, input logic [3:0] e);
		act[n_rows] = a;
		arg[n_rows] = g;
		e_num1[n_rows] = n1;
		e_num2[n_rows] = n2;
		e_val[n_rows] = v;
		e_err[n_rows] = e;
		n_rows++;
	endtask

	// odd display of each pair shows the tens digit
	task automatic set_expected(input int r);
		exp_hex[0] = seg_pattern(e_num1[r] % 10);
		exp_hex[1] = seg_pattern(e_num1[r] / 10);
		exp_hex[2] = seg_pattern(e_num2[r] % 10);
		exp_hex[3] = seg_pattern(e_num2[r] / 10);
		exp_hex[4] = seg_pattern(e_val[r] % 10);
		exp_hex[5] = seg_pattern(e_val[r] / 10);
		exp_hex[6] = seg_pattern(e_err[r] % 10);
		exp_hex[7] = seg_pattern(e_err[r] / 10);
	endtask

	function automatic bit hex_match();
		for (int i = 0; i < 8; i++) begin
			if (hex[i] !== exp_hex[i]) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("Fail time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
		errors++;
	endtask

	// hold low for len cycles, then give the release time to settle
	task automatic press_key(input int idx, input int len);
		key[idx] = 1'b0;
		repeat (len) @(negedge clk);
		key[idx] = 1'b1;
		repeat (DEB_CYCLES + 6) @(negedge clk);
	endtask

	task automatic send_ps2(input logic [7:0] code, input bit bad_par);
		logic [10:0] frame;
		frame = {1'b1, (~^code) ^ bad_par, code, 1'b0};
		for (int i = 0; i < 11; i++) begin
			ps2_dat = frame[i];
			repeat (PS2_HALF) @(negedge clk);
			ps2_clk = 1'b0;
			repeat (PS2_HALF) @(negedge clk);
			ps2_clk = 1'b1;
		end
		ps2_dat = 1'b1;
		repeat (PS2_HALF) @(negedge clk);
	endtask

	task automatic apply_row(input int r);
		case (act[r])
			ACT_KEY: press_key(arg[r], DEB_CYCLES + 8);
			ACT_GLITCH: press_key(arg[r], DEB_CYCLES / 2);
			ACT_PS2: send_ps2(arg[r], 1'b0);
			ACT_PS2_BAD: send_ps2(arg[r], 1'b1);
			default: @(negedge clk);
		endcase
	endtask

	// watch two full frames of sync timing and the flat colour
	task automatic check_vga(input logic [3:0] n1, input logic [3:0] n2, input logic [3:0] v);
		int hs_fall;
		int vs_fall;
		int n_hs;
		int n_vs;
		int n_act;
		logic hs_d;
		logic vs_d;
		logic [7:0] r_exp;
		r_exp = {v, v};
		hs_fall = -1;
		vs_fall = -1;
		n_hs = 0;
		n_vs = 0;
		n_act = 0;
		@(negedge clk);
		hs_d = vga_hs;
		vs_d = vga_vs;
		for (int c = 0; c < VGA_CLKS; c++) begin
			@(negedge clk);
			if (hs_d && !vga_hs) begin
				if (hs_fall >= 0 && c - hs_fall != LINE_CLKS)
					report_mismatch("o_vga_hs period", c - hs_fall, LINE_CLKS);
				hs_fall = c;
				n_hs++;
			end
			if (!hs_d && vga_hs && hs_fall >= 0 && c - hs_fall != HS_CLKS)
				report_mismatch("o_vga_hs low width", c - hs_fall, HS_CLKS);
			if (vs_d && !vga_vs) begin
				if (vs_fall >= 0 && c - vs_fall != FRAME_CLKS)
					report_mismatch("o_vga_vs period", c - vs_fall, FRAME_CLKS);
				vs_fall = c;
				n_vs++;
			end
			if (!vs_d && vga_vs && vs_fall >= 0 && c - vs_fall != VS_CLKS)
				report_mismatch("o_vga_vs low width", c - vs_fall, VS_CLKS);
			if (vga_blank_n) begin
				n_act++;
				if (vga_r !== r_exp)
					report_mismatch("o_vga_r", vga_r, r_exp);
				if (vga_g !== ~r_exp)
					report_mismatch("o_vga_g", vga_g, ~r_exp);
				if (vga_b !== {n2, n1})
					report_mismatch("o_vga_b", vga_b, {n2, n1});
			end else if (vga_r !== 8'h00 || vga_g !== 8'h00 || vga_b !== 8'h00) begin
				report_mismatch("o_vga_rgb in blanking", {vga_r, vga_g, vga_b}, 0);
			end
			hs_d = vga_hs;
			vs_d = vga_vs;
		end
		if (n_hs < 2 || n_vs < 2) begin
			$display("VGA sync pulses missing: %0d hsync and %0d vsync falls seen", n_hs, n_vs);
			errors++;
		end
		if (n_act == 0) begin
			$display("VGA blank_n never went high during the observed frames");
			errors++;
		end
	endtask

	initial begin
		seed = 32'h3df1;
		errors = 0;
		timeouts = 0;
		n_rows = 0;
		key = 3'b111;
		ps2_clk = 1'b1;
		ps2_dat = 1'b1;

		add_row(ACT_WAIT, 8'h00, 4'd0, 4'd0, 4'd0, 4'd0);
		// wrap both ways, then glitch and clear
		add_row(ACT_KEY, 8'd1, 4'd0, 4'd0, 4'd15, 4'd0);
		add_row(ACT_KEY, 8'd0, 4'd0, 4'd0, 4'd0, 4'd0);
		add_row(ACT_KEY, 8'd0, 4'd0, 4'd0, 4'd1, 4'd0);
		add_row(ACT_KEY, 8'd0, 4'd0, 4'd0, 4'd2, 4'd0);
		add_row(ACT_GLITCH, 8'd0, 4'd0, 4'd0, 4'd2, 4'd0);
		add_row(ACT_KEY, 8'd2, 4'd0, 4'd0, 4'd0, 4'd0);
		// keyboard digits 3 and 7, then break and non-digit codes
		add_row(ACT_PS2, 8'h26, 4'd3, 4'd0, 4'd0, 4'd0);
		add_row(ACT_PS2, 8'h3d, 4'd7, 4'd3, 4'd0, 4'd0);
		add_row(ACT_PS2, 8'hf0, 4'd7, 4'd3, 4'd0, 4'd0);
		add_row(ACT_PS2, 8'h26, 4'd7, 4'd3, 4'd0, 4'd0);
		add_row(ACT_PS2, 8'h1c, 4'd7, 4'd3, 4'd0, 4'd0);
		add_row(ACT_PS2_BAD, 8'h16, 4'd7, 4'd3, 4'd0, 4'd1);
		add_row(ACT_PS2_BAD, 8'h45, 4'd7, 4'd3, 4'd0, 4'd2);
		add_row(ACT_PS2, 8'h16, 4'd1, 4'd7, 4'd0, 4'd2);
		// a value whose colour differs from the blanking level
		add_row(ACT_KEY, 8'd0, 4'd1, 4'd7, 4'd1, 4'd2);

		// still in reset here
		@(negedge clk);
		if (vga_blank_n !== 1'b0)
			report_mismatch("o_vga_blank_n", vga_blank_n, 1'b0);
		if (vga_hs !== 1'b1)
			report_mismatch("o_vga_hs", vga_hs, 1'b1);
		if (vga_vs !== 1'b1)
			report_mismatch("o_vga_vs", vga_vs, 1'b1);
		for (int i = 0; i < 8; i++) begin
			if (hex[i] !== seg_pattern(0))
				report_mismatch($sformatf("o_hex%0d", i), hex[i], seg_pattern(0));
		end

		cnt = 0;
		while (arst_n !== 1'b1 && cnt < 20) begin
			@(negedge clk);
			cnt++;
		end
		if (arst_n !== 1'b1) begin
			$display("timeout waiting for reset release");
			timeouts++;
		end

		for (int r = 0; r < n_rows; r++) begin
			apply_row(r);
			repeat (2 + $unsigned($random(seed)) % 8) @(negedge clk);
			set_expected(r);
			cnt = 0;
			while (!hex_match() && cnt < WAIT_LIMIT) begin
				@(negedge clk);
				cnt++;
			end
			if (!hex_match()) begin
				$display("timeout waiting for the displays to settle on row %0d", r);
				timeouts++;
			end
			for (int i = 0; i < 8; i++) begin
				if (hex[i] !== exp_hex[i])
					report_mismatch($sformatf("o_hex%0d", i), hex[i], exp_hex[i]);
			end
		end

		check_vga(e_num1[n_rows-1], e_num2[n_rows-1], e_val[n_rows-1]);

		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== vga_pkg.sv ====
package vga_pkg;

	// horizontal or vertical position, wide enough for 640x480 timing
	typedef logic [10:0] pix_cnt_t;

	// one colour channel of the DAC
	typedef logic [7:0] color_t;

endpackage

// ==== vga_sync.sv ====
module vga_sync #(
	parameter int H_ACTIVE = 640,
	parameter int H_FP     = 16,
	parameter int H_SYNC   = 96,
	parameter int H_BP     = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FP     = 10,
	parameter int V_SYNC   = 2,
	parameter int V_BP     = 33
) (
	input  logic              i_clk,
	input  logic              i_arst_n,
	input  disp_pkg::digit_t  i_num1,
	input  disp_pkg::digit_t  i_num2,
	input  disp_pkg::digit_t  i_value,
	output vga_pkg::color_t   o_vga_r,
	output vga_pkg::color_t   o_vga_g,
	output vga_pkg::color_t   o_vga_b,
	output logic              o_vga_hs,
	output logic              o_vga_vs,
	output logic              o_vga_blank_n
);

	import vga_pkg::*;

	localparam pix_cnt_t H_LAST   = pix_cnt_t'(H_ACTIVE + H_FP + H_SYNC + H_BP - 1);
	localparam pix_cnt_t V_LAST   = pix_cnt_t'(V_ACTIVE + V_FP + V_SYNC + V_BP - 1);
	localparam pix_cnt_t H_ACT    = pix_cnt_t'(H_ACTIVE);
	localparam pix_cnt_t V_ACT    = pix_cnt_t'(V_ACTIVE);
	localparam pix_cnt_t HS_START = pix_cnt_t'(H_ACTIVE + H_FP);
	localparam pix_cnt_t HS_END   = pix_cnt_t'(H_ACTIVE + H_FP + H_SYNC);
	localparam pix_cnt_t VS_START = pix_cnt_t'(V_ACTIVE + V_FP);
	localparam pix_cnt_t VS_END   = pix_cnt_t'(V_ACTIVE + V_FP + V_SYNC);

	pix_cnt_t h_cnt;
	pix_cnt_t v_cnt;
	logic active;
	color_t r_flat;

	// free running position counters
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_cnt == H_LAST) begin
			h_cnt <= '0;
			v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + pix_cnt_t'(1);
		end else begin
			h_cnt <= h_cnt + pix_cnt_t'(1);
		end
	end

	assign active = (h_cnt < H_ACT) && (v_cnt < V_ACT);
	assign r_flat = {i_value, i_value};

	// sync, blanking and colour all leave through one register stage
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_vga_hs      <= 1'b1;
			o_vga_vs      <= 1'b1;
			o_vga_blank_n <= 1'b0;
			o_vga_r       <= '0;
			o_vga_g       <= '0;
			o_vga_b       <= '0;
		end else begin
			o_vga_hs      <= !((h_cnt >= HS_START) && (h_cnt < HS_END));
			o_vga_vs      <= !((v_cnt >= VS_START) && (v_cnt < VS_END));
			o_vga_blank_n <= active;
			o_vga_r       <= active ? r_flat : '0;
			o_vga_g       <= active ? ~r_flat : '0;
			o_vga_b       <= active ? {i_num2, i_num1} : '0;
		end
	end

	a_h_cnt_range : assert property (@(posedge i_clk) disable iff (!i_arst_n)
		h_cnt <= H_LAST);

endmodule
